// ==== common/pulse_filter_pkg.sv ====
package pulse_filter_pkg;

	// Sample format 1s17, pair sums 2s17
	localparam int SAMPLE_W = 18;
	localparam int PAIR_W = SAMPLE_W + 1;

	// One level step of the PAM alphabet is 2**FRAC_W
	localparam int FRAC_W = 15;

	// Tap count must be odd so there is a single center tap
	localparam int NUM_TAPS_DEFAULT = 21;

	// Index 0 is the outermost pair, the last entry is the center tap
	localparam int coeff_table [0:(NUM_TAPS_DEFAULT-1)/2] = '{
		-1601,
		1483,
		291,
		-1484,
		-2824,
		-2631,
		-301,
		3876,
		8715,
		12571,
		14041
	};

	// One input sample, seen as a number or as level plus fraction
	typedef union packed
	{
		logic signed [SAMPLE_W-1:0] raw;
		struct packed
		{
			logic signed [SAMPLE_W-FRAC_W-1:0] level;
			logic [FRAC_W-1:0] frac;
		} lvl;
	} sample_word_u;

	// Sum of a folded pair, one bit wider than a sample
	typedef union packed
	{
		logic signed [PAIR_W-1:0] raw;
		struct packed
		{
			logic signed [PAIR_W-FRAC_W-1:0] level;
			logic [FRAC_W-1:0] frac;
		} lvl;
	} pair_sum_u;

	// Only whole levels reachable from two PAM4 symbols count.
	// The center tap sees a single symbol, so even levels are out there.
	function automatic logic level_is_legal(input pair_sum_u word, input logic is_center);
		logic legal;
		if (word.lvl.frac != '0)
		begin
			legal = 1'b0;
		end
		else if (is_center)
		begin
			case (word.lvl.level)
				0, 1, -1, 3, -3: legal = 1'b1;
				default: legal = 1'b0;
			endcase
		end
		else
		begin
			case (word.lvl.level)
				0, 1, -1, 2, -2: legal = 1'b1;
				3, -3, 4, -4: legal = 1'b1;
				6, -6: legal = 1'b1;
				default: legal = 1'b0;
			endcase
		end
		return legal;
	endfunction

endpackage

// ==== src/sample_delay_line.sv ====
`timescale 1ns/1ps

module sample_delay_line
	import pulse_filter_pkg::*;
#(
	parameter int NUM_TAPS = NUM_TAPS_DEFAULT,
	localparam int HALF_TAPS = (NUM_TAPS - 1) / 2
)
(
	input logic clk,
	input logic reset,
	input logic sam_clk_en,
	input sample_word_u x_in,
	output sample_word_u pair_near [0:HALF_TAPS-1],
	output sample_word_u pair_far [0:HALF_TAPS-1],
	output sample_word_u center_sample
);

	// stage[0] holds the newest sample
	sample_word_u stage [0:NUM_TAPS-1];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_TAPS; i++)
			begin
				stage[i] <= '0;
			end
		end
		else if (sam_clk_en)
		begin
			stage[0] <= x_in;
			for (int i = 1; i < NUM_TAPS; i++)
			begin
				stage[i] <= stage[i-1];
			end
		end
	end

	// Fold the line around its middle stage
	for (genvar i = 0; i < HALF_TAPS; i++)
	begin : fold_gen
		assign pair_near[i] = stage[i];
		assign pair_far[i] = stage[NUM_TAPS-1-i];
	end

	assign center_sample = stage[HALF_TAPS];

endmodule

// ==== src/folded_tap.sv ====
`timescale 1ns/1ps

module folded_tap
	import pulse_filter_pkg::*;
#(
	parameter int COEFF = 0,
	parameter bit IS_CENTER = 1'b0
)
(
	input sample_word_u near,
	input sample_word_u far,
	output logic signed [SAMPLE_W-1:0] product
);

	localparam int LEVEL_W = PAIR_W - FRAC_W;

	// Room for the coefficient times six before wrapping to SAMPLE_W
	localparam int PROD_W = SAMPLE_W + 3;

	localparam logic signed [PROD_W-1:0] COEFF_X1 = PROD_W'(COEFF);
	localparam logic signed [PROD_W-1:0] COEFF_X2 = COEFF_X1 <<< 1;
	localparam logic signed [PROD_W-1:0] COEFF_X4 = COEFF_X1 <<< 2;

	logic signed [PAIR_W-1:0] near_ext;
	logic signed [PAIR_W-1:0] far_ext;
	pair_sum_u pair_sum;
	logic pair_legal;
	logic level_neg;
	logic [LEVEL_W-1:0] level_mag;
	logic signed [PROD_W-1:0] mag_product;
	logic signed [PROD_W-1:0] signed_product;

	// Pre-add, the center tap has no partner
	assign near_ext = {near.raw[SAMPLE_W-1], near.raw};
	assign far_ext = IS_CENTER ? '0 : {far.raw[SAMPLE_W-1], far.raw};
	assign pair_sum.raw = near_ext + far_ext;

	assign pair_legal = level_is_legal(pair_sum, IS_CENTER);

	// Split the level into sign and magnitude
	always_comb
	begin
		level_neg = pair_sum.lvl.level[LEVEL_W-1];
		if (level_neg)
		begin
			level_mag = LEVEL_W'(-pair_sum.lvl.level);
		end
		else
		begin
			level_mag = pair_sum.lvl.level;
		end
	end

	// Shift-and-add in place of a multiplier
	always_comb
	begin
		case (level_mag)
			1: mag_product = COEFF_X1;
			2: mag_product = COEFF_X2;
			3: mag_product = COEFF_X2 + COEFF_X1;
			4: mag_product = COEFF_X4;
			6: mag_product = COEFF_X4 + COEFF_X2;
			default: mag_product = '0;
		endcase
	end

	assign signed_product = level_neg ? -mag_product : mag_product;

	// Illegal pair sums drop out of the filter sum
	always_comb
	begin
		if (pair_legal)
		begin
			product = signed_product[SAMPLE_W-1:0];
		end
		else
		begin
			product = '0;
		end
	end

endmodule

// ==== src/tap_adder_tree.sv ====
`timescale 1ns/1ps

module tap_adder_tree
	import pulse_filter_pkg::*;
#(
	parameter int NUM_TAPS = NUM_TAPS_DEFAULT,
	localparam int HALF_TAPS = (NUM_TAPS - 1) / 2
)
(
	input logic clk,
	input logic reset,
	input logic sam_clk_en,
	input logic signed [SAMPLE_W-1:0] product [0:HALF_TAPS],
	output logic signed [SAMPLE_W-1:0] y
);

	localparam int NUM_PROD = HALF_TAPS + 1;

	// Each level halves the node count, rounding up
	localparam int NUM_LEVELS = $clog2(NUM_PROD);

	// Number of live nodes at a given tree level
	function automatic int level_count(input int level);
		int count;
		count = NUM_PROD;
		for (int l = 0; l < level; l++)
		begin
			count = (count + 1) / 2;
		end
		return count;
	endfunction

	// Level 0 is the product array, the last level holds the total
	logic signed [SAMPLE_W-1:0] node [0:NUM_LEVELS][0:NUM_PROD-1];

	for (genvar j = 0; j < NUM_PROD; j++)
	begin : leaf_gen
		assign node[0][j] = product[j];
	end

	for (genvar l = 1; l <= NUM_LEVELS; l++)
	begin : level_gen
		localparam int PREV_COUNT = level_count(l - 1);

		for (genvar j = 0; j < NUM_PROD; j++)
		begin : node_gen
			if (2*j + 1 < PREV_COUNT)
			begin : add_gen
				// Sums wrap at SAMPLE_W like the output
				assign node[l][j] = node[l-1][2*j] + node[l-1][2*j+1];
			end
			else if (2*j < PREV_COUNT)
			begin : carry_gen
				// Odd node out moves up unchanged
				assign node[l][j] = node[l-1][2*j];
			end
			else
			begin : idle_gen
				assign node[l][j] = '0;
			end
		end
	end

	// Output only updates on a sample strobe
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			y <= '0;
		end
		else if (sam_clk_en)
		begin
			y <= node[NUM_LEVELS][0];
		end
	end

endmodule

// ==== src/pulse_shaping_filter.sv ====
`timescale 1ns/1ps

module pulse_shaping_filter
	import pulse_filter_pkg::*;
#(
	parameter int NUM_TAPS = NUM_TAPS_DEFAULT,
	localparam int HALF_TAPS = (NUM_TAPS - 1) / 2
)
(
	input logic clk,
	input logic reset,
	input logic sam_clk_en,
	input logic signed [SAMPLE_W-1:0] x_in,
	output logic signed [SAMPLE_W-1:0] y
);

	sample_word_u pair_near [0:HALF_TAPS-1];
	sample_word_u pair_far [0:HALF_TAPS-1];
	sample_word_u center_sample;
	logic signed [SAMPLE_W-1:0] product [0:HALF_TAPS];

	sample_delay_line #(
		.NUM_TAPS(NUM_TAPS)
	) sample_delay_line_inst (
		.clk(clk),
		.reset(reset),
		.sam_clk_en(sam_clk_en),
		.x_in(x_in),
		.pair_near(pair_near),
		.pair_far(pair_far),
		.center_sample(center_sample)
	);

	// One tap per coefficient, the last one is the center
	for (genvar i = 0; i <= HALF_TAPS; i++)
	begin : tap_gen
		if (i < HALF_TAPS)
		begin : pair_gen
			folded_tap #(
				.COEFF(coeff_table[i]),
				.IS_CENTER(1'b0)
			) folded_tap_inst (
				.near(pair_near[i]),
				.far(pair_far[i]),
				.product(product[i])
			);
		end
		else
		begin : center_gen
			folded_tap #(
				.COEFF(coeff_table[i]),
				.IS_CENTER(1'b1)
			) folded_tap_inst (
				.near(center_sample),
				.far('0),
				.product(product[i])
			);
		end
	end

	tap_adder_tree #(
		.NUM_TAPS(NUM_TAPS)
	) tap_adder_tree_inst (
		.clk(clk),
		.reset(reset),
		.sam_clk_en(sam_clk_en),
		.product(product),
		.y(y)
	);

endmodule

// ==== test/pulse_filter_vectors.svh ====
// Each row is one clock cycle of stimulus.
// The columns are strobe, x_in, check flag and expected y after the cycle.

task automatic load_vector_table();
	// Idle after reset, x_in moves without a strobe
	add_row(1'b0, 18'h08000, 1'b1, 0);
	add_row(1'b0, 18'h18000, 1'b1, 0);
	add_row(1'b0, 18'h38000, 1'b1, 0);
	add_row(1'b0, 18'h28000, 1'b1, 0);
	add_row(1'b0, 18'h00001, 1'b1, 0);
	add_row(1'b0, 18'h3ffff, 1'b1, 0);
	add_row(1'b0, 18'h08000, 1'b1, 0);
	add_row(1'b0, 18'h18000, 1'b1, 0);
	add_row(1'b0, 18'h38000, 1'b1, 0);
	add_row(1'b0, 18'h28000, 1'b1, 0);

	// Impulse of one level step walks through the coefficients
	add_row(1'b1, 18'h08000, 1'b1, 0);
	add_row(1'b1, 18'h00000, 1'b1, -1601);
	add_row(1'b1, 18'h00000, 1'b1, 1483);
	add_row(1'b1, 18'h00000, 1'b1, 291);
	add_row(1'b1, 18'h00000, 1'b1, -1484);
	// Output holds between strobes
	add_row(1'b0, 18'h18000, 1'b1, -1484);
	add_row(1'b0, 18'h28000, 1'b1, -1484);
	add_row(1'b0, 18'h00001, 1'b1, -1484);
	add_row(1'b1, 18'h00000, 1'b1, -2824);
	add_row(1'b1, 18'h00000, 1'b1, -2631);
	add_row(1'b1, 18'h00000, 1'b1, -301);
	add_row(1'b1, 18'h00000, 1'b1, 3876);
	add_row(1'b1, 18'h00000, 1'b1, 8715);
	add_row(1'b1, 18'h00000, 1'b1, 12571);
	add_row(1'b1, 18'h00000, 1'b1, 14041);
	add_row(1'b1, 18'h00000, 1'b1, 12571);
	add_row(1'b1, 18'h00000, 1'b1, 8715);
	add_row(1'b1, 18'h00000, 1'b1, 3876);
	add_row(1'b1, 18'h00000, 1'b1, -301);
	add_row(1'b1, 18'h00000, 1'b1, -2631);
	add_row(1'b1, 18'h00000, 1'b1, -2824);
	add_row(1'b1, 18'h00000, 1'b1, -1484);
	add_row(1'b1, 18'h00000, 1'b1, 291);
	add_row(1'b1, 18'h00000, 1'b1, 1483);
	add_row(1'b1, 18'h00000, 1'b1, -1601);
	add_row(1'b1, 18'h00000, 1'b1, 0);

	// A word with fraction bits two samples behind the impulse.
	// It never counts, and it cancels the impulse where they pair up.
	add_row(1'b1, 18'h08000, 1'b1, 0);
	add_row(1'b1, 18'h00000, 1'b1, -1601);
	add_row(1'b1, 18'h00001, 1'b1, 1483);
	add_row(1'b1, 18'h00000, 1'b1, 291);
	add_row(1'b1, 18'h00000, 1'b1, -1484);
	add_row(1'b1, 18'h00000, 1'b1, -2824);
	add_row(1'b1, 18'h00000, 1'b1, -2631);
	add_row(1'b1, 18'h00000, 1'b1, -301);
	add_row(1'b1, 18'h00000, 1'b1, 3876);
	add_row(1'b1, 18'h00000, 1'b1, 8715);
	add_row(1'b1, 18'h00000, 1'b1, 12571);
	add_row(1'b1, 18'h00000, 1'b1, 14041);
	add_row(1'b1, 18'h00000, 1'b1, 0);
	add_row(1'b1, 18'h00000, 1'b1, 8715);
	add_row(1'b1, 18'h00000, 1'b1, 3876);
	add_row(1'b1, 18'h00000, 1'b1, -301);
	add_row(1'b1, 18'h00000, 1'b1, -2631);
	add_row(1'b1, 18'h00000, 1'b1, -2824);
	add_row(1'b1, 18'h00000, 1'b1, -1484);
	add_row(1'b1, 18'h00000, 1'b1, 291);
	add_row(1'b1, 18'h00000, 1'b1, 1483);
	add_row(1'b1, 18'h00000, 1'b1, -1601);
	add_row(1'b1, 18'h00000, 1'b1, 0);
	add_row(1'b1, 18'h00000, 1'b1, 0);
endtask

// ==== test/pulse_filter_tb.sv ====
`timescale 1ns/1ps

module pulse_filter_tb
	import pulse_filter_pkg::*;
;

	localparam int NUM_TAPS = NUM_TAPS_DEFAULT;
	localparam int HALF_TAPS = (NUM_TAPS - 1) / 2;
	localparam int RANDOM_STROBES = 200;
	localparam int MAX_Y = 2**(SAMPLE_W-1) - 1;
	localparam int MIN_Y = -(2**(SAMPLE_W-1));

	logic clk;
	logic reset;
	logic sam_clk_en;
	logic signed [SAMPLE_W-1:0] x_in;
	logic signed [SAMPLE_W-1:0] y;

	// Stimulus table
	logic row_strobe [$];
	logic signed [SAMPLE_W-1:0] row_x [$];
	logic row_check [$];
	int row_expected [$];

	// Reference copy of the delay line
	// Index 0 holds the newest sample
	int model_line [0:NUM_TAPS-1];
	logic signed [SAMPLE_W-1:0] model_y;

	int error_count;
	int check_count;
	int wrap_count;
	int cycle_count;
	int timeout_limit;

	pulse_shaping_filter #(
		.NUM_TAPS(NUM_TAPS)
	) pulse_shaping_filter_inst (
		.clk(clk),
		.reset(reset),
		.sam_clk_en(sam_clk_en),
		.x_in(x_in),
		.y(y)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count++;
		if (timeout_limit > 0 && cycle_count >= timeout_limit)
		begin
			$display("Timeout after %0d cycles, the stimulus did not complete", cycle_count);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic add_row(input logic strobe, input logic [SAMPLE_W-1:0] x,
		input logic check, input int expected);
		row_strobe.push_back(strobe);
		row_x.push_back(x);
		row_check.push_back(check);
		row_expected.push_back(expected);
	endtask

	`include "pulse_filter_vectors.svh"

	// Coefficient times level for one pair sum or zero off the level grid
	function automatic int tap_term(input int pair_value, input int coeff, input bit center);
		int level;
		bit legal;
		level = pair_value >>> FRAC_W;
		legal = 1'b0;
		if ((pair_value & (2**FRAC_W - 1)) == 0)
		begin
			if (center)
			begin
				legal = (level == 0 || level == 1 || level == -1 || level == 3 || level == -3);
			end
			else
			begin
				legal = (level >= -4 && level <= 4) || level == 6 || level == -6;
			end
		end
		return legal ? coeff * level : 0;
	endfunction

	function automatic int model_sum();
		int total;
		total = 0;
		for (int i = 0; i < HALF_TAPS; i++)
		begin
			total += tap_term(model_line[i] + model_line[NUM_TAPS-1-i], coeff_table[i], 1'b0);
		end
		total += tap_term(model_line[HALF_TAPS], coeff_table[HALF_TAPS], 1'b1);
		return total;
	endfunction

	function automatic logic signed [SAMPLE_W-1:0] pam4_sample(input int pick);
		case (pick)
			0: return SAMPLE_W'(-98304);
			1: return SAMPLE_W'(-32768);
			2: return SAMPLE_W'(32768);
			default: return SAMPLE_W'(98304);
		endcase
	endfunction

	// Drive one cycle, update the model on a strobe and compare y after the edge
	task automatic apply_cycle(input logic strobe, input logic signed [SAMPLE_W-1:0] x);
		int total;
		sam_clk_en = strobe;
		x_in = x;
		if (strobe)
		begin
			total = model_sum();
			if (total > MAX_Y || total < MIN_Y)
			begin
				wrap_count++;
			end
			model_y = total[SAMPLE_W-1:0];
			for (int i = NUM_TAPS - 1; i > 0; i--)
			begin
				model_line[i] = model_line[i-1];
			end
			model_line[0] = x;
		end
		@(posedge clk);
		#1;
		check_count++;
		assert (y === model_y)
		else
		begin
			$display("[ERROR] y at cycle %0d: got %h, expected %h", cycle_count, y, model_y);
			error_count++;
		end
	endtask

	task automatic check_table_row(input int r);
		logic signed [SAMPLE_W-1:0] expected;
		expected = SAMPLE_W'(row_expected[r]);
		check_count++;
		assert (y === expected)
		else
		begin
			$display("[ERROR] y at table row %0d: got %h, expected %h", r, y, expected);
			error_count++;
		end
	endtask

	// PAM4 stream on random strobes with a run of +3 that drives the sum past full scale
	task automatic run_random_phase();
		int sent;
		logic strobe;
		logic signed [SAMPLE_W-1:0] x;
		sent = 0;
		while (sent < RANDOM_STROBES)
		begin
			strobe = $urandom % 2;
			if (sent >= 60 && sent < 90)
			begin
				x = pam4_sample(3);
			end
			else
			begin
				x = pam4_sample($urandom % 4);
			end
			apply_cycle(strobe, x);
			if (strobe)
			begin
				sent++;
			end
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		sam_clk_en = 1'b0;
		x_in = '0;
		model_y = '0;
		error_count = 0;
		check_count = 0;
		wrap_count = 0;
		cycle_count = 0;
		timeout_limit = 0;
		for (int i = 0; i < NUM_TAPS; i++)
		begin
			model_line[i] = 0;
		end
		void'($urandom(64220));
		load_vector_table();
		timeout_limit = row_strobe.size() + RANDOM_STROBES * 4 + 50;

		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int r = 0; r < row_strobe.size(); r++)
		begin
			apply_cycle(row_strobe[r], row_x[r]);
			if (row_check[r])
			begin
				check_table_row(r);
			end
		end

		run_random_phase();

		$display("Summary: %0d errors in %0d checks, %0d wrapped sums", error_count,
			check_count, wrap_count);
		if (error_count == 0)
		begin
			$display("TEST PASS");
		end
		else
		begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+test
common/pulse_filter_pkg.sv
src/sample_delay_line.sv
src/folded_tap.sv
src/tap_adder_tree.sv
src/pulse_shaping_filter.sv
test/pulse_filter_tb.sv
